/* verilog/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    localparam int IMG_WIDTH   = 8;     // Columns per image row
    localparam int KERNEL_SIZE = 3;     // Window side
    localparam int FRAC_BITS   = 16;    // Q15.16 fraction
    localparam int PIXEL_BITS  = 32;

    typedef logic signed [PIXEL_BITS-1:0]   pixel_t;    // Pixel, weight or bias
    typedef logic signed [2*PIXEL_BITS-1:0] acc_t;      // Full width product sum
    typedef logic [$clog2(IMG_WIDTH)-1:0]   col_t;

    // One window column, top of the image first
    typedef struct packed {
        pixel_t oldest;
        pixel_t middle;
        pixel_t newest;     // Live input pixel
    } column_t;

    typedef struct packed {
        column_t left;
        column_t middle;
        column_t right;
    } window_t;

    // Weight index is row * KERNEL_SIZE + column, row 0 being the oldest row
    typedef struct packed {
        pixel_t [KERNEL_SIZE*KERNEL_SIZE-1:0] weight;
        pixel_t                               bias;
    } coeff_t;

    typedef enum logic [1:0] {
        WS_PRIME,       // First two rows go to the line RAMs
        WS_STREAM,      // Windows complete from column 2 on
        WS_FLUSH        // Last pixel taken, pipeline draining
    } win_state_t;

endpackage

`default_nettype wire

/* verilog/window_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module window_ctrl import conv_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic i_valid,
    input  wire logic i_last,
    input  wire logic i_hold,         // Output stage full and not taken
    output logic      o_ready_in,
    output logic      o_accept,
    output col_t      o_wr_col,       // Column written on this accept
    output col_t      o_rd_col,       // Column read for the next cycle
    output logic      o_row_sel,      // Line RAM with the oldest row
    output logic      o_win_valid,
    output logic      o_win_last
);

    win_state_t state_q;
    win_state_t state_d;
    col_t       col_q;
    col_t       col_d;
    logic       row_sel_q;
    logic       row_sel_d;
    logic [1:0] flush_cnt_q;          // Pipeline steps since the last pixel
    logic [1:0] flush_cnt_d;
    logic       run_q;                // Low only through reset
    logic       row_end;

    assign row_end    = (col_q == col_t'(IMG_WIDTH-1));
    assign o_ready_in = run_q && (state_q != WS_FLUSH) && !i_hold;
    assign o_accept   = i_valid && o_ready_in;

    // Qualified by accept in the MAC
    assign o_win_valid = (state_q == WS_STREAM) && (col_q >= col_t'(KERNEL_SIZE-1));
    assign o_win_last  = o_win_valid && i_last;

    assign o_wr_col  = col_q;
    assign o_rd_col  = col_d;        // Registered read lands with the next pixel
    assign o_row_sel = row_sel_q;

    always_comb begin
        state_d     = state_q;
        col_d       = col_q;
        row_sel_d   = row_sel_q;
        flush_cnt_d = flush_cnt_q;
        if (o_accept) begin
            col_d = row_end ? '0 : col_q + 1'b1;
            if (row_end) begin
                row_sel_d = ~row_sel_q;             // Freshest row becomes the middle one
                if (state_q == WS_PRIME && row_sel_q) begin
                    state_d = WS_STREAM;            // Two rows buffered
                end
            end
            if (i_last) begin
                state_d = WS_FLUSH;
            end
        end else if (state_q == WS_FLUSH && !i_hold) begin
            // Third free step is the o_last transfer
            if (flush_cnt_q == 2'd2) begin
                state_d     = WS_PRIME;
                col_d       = '0;
                row_sel_d   = 1'b0;
                flush_cnt_d = '0;
            end else begin
                flush_cnt_d = flush_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= WS_PRIME;
            col_q       <= '0;
            row_sel_q   <= 1'b0;
            flush_cnt_q <= '0;
            run_q       <= 1'b0;
        end else begin
            state_q     <= state_d;
            col_q       <= col_d;
            row_sel_q   <= row_sel_d;
            flush_cnt_q <= flush_cnt_d;
            run_q       <= 1'b1;
        end
    end

    // Input stays closed from the last pixel until the controller is back in PRIME
    a_flush_closed: assert property (@(posedge clk) disable iff (reset)
        o_accept && i_last |=> !o_accept until (state_q == WS_PRIME));

    a_col_range: assert property (@(posedge clk) disable iff (reset)
        o_accept |-> (o_wr_col < IMG_WIDTH) && (o_rd_col < IMG_WIDTH));

endmodule

`default_nettype wire

/* verilog/line_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module line_buffer import conv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire pixel_t i_pixel,
    input  wire logic   i_accept,
    input  wire col_t   i_wr_col,
    input  wire col_t   i_rd_col,
    input  wire logic   i_row_sel,      // RAM holding the oldest row
    output column_t     o_column
);

    pixel_t ram_q [2][IMG_WIDTH];       // Two previous image rows
    pixel_t rd_q  [2];                  // Registered read port per RAM

    // The oldest row is overwritten as the new row comes in
    always_ff @(posedge clk) begin
        if (i_accept) begin
            ram_q[i_row_sel][i_wr_col] <= i_pixel;
        end
    end

    // Both RAMs read the same column, ordered below
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q[0] <= '0;
            rd_q[1] <= '0;
        end else begin
            rd_q[0] <= ram_q[0][i_rd_col];
            rd_q[1] <= ram_q[1][i_rd_col];
        end
    end

    assign o_column = '{
        oldest: i_row_sel ? rd_q[1] : rd_q[0],
        middle: i_row_sel ? rd_q[0] : rd_q[1],
        newest: i_pixel                 // Current row straight from the input
    };

endmodule

`default_nettype wire

/* verilog/window_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module window_regs import conv_pkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    i_accept,
    input  wire column_t i_column,      // New right hand column
    output window_t      o_window
);

    // Sliding 3x3 window, one column per accepted pixel
    // Columns straddling a row change are garbage until column 2 of the new row
    always_ff @(posedge clk) begin
        if (reset) begin
            o_window <= '0;
        end else if (i_accept) begin
            o_window.left   <= o_window.middle;
            o_window.middle <= o_window.right;
            o_window.right  <= i_column;
        end
    end

endmodule

`default_nettype wire

/* verilog/kernel_mac.sv */
`timescale 1ns/10ps
`default_nettype none

module kernel_mac import conv_pkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire window_t i_window,
    input  wire coeff_t  i_coeff,
    input  wire logic    i_relu_en,
    input  wire logic    i_accept,
    input  wire logic    i_win_valid,
    input  wire logic    i_win_last,
    input  wire logic    i_ready,
    output pixel_t       o_data,
    output logic         o_valid,
    output logic         o_last,
    output logic         o_hold
);

    logic    a_vld_q;           // Window completes on this accept
    logic    a_last_q;
    logic    b_vld_q;           // Captured window holds a result
    logic    b_last_q;
    window_t win_q;
    column_t cols [KERNEL_SIZE];
    acc_t    acc;
    pixel_t  scaled;
    pixel_t  biased;
    pixel_t  result;

    function automatic acc_t mul(pixel_t a, pixel_t b);
        return acc_t'(a) * acc_t'(b);   // Sign extended full product
    endfunction

    assign o_hold = o_valid && !i_ready;

    // Whole pipeline stalls in lockstep with the window controller
    always_ff @(posedge clk) begin
        if (reset) begin
            a_vld_q  <= 1'b0;
            a_last_q <= 1'b0;
            b_vld_q  <= 1'b0;
            b_last_q <= 1'b0;
            o_valid  <= 1'b0;
            o_last   <= 1'b0;
        end else if (!o_hold) begin
            a_vld_q  <= i_accept && i_win_valid;
            a_last_q <= i_accept && i_win_last;
            b_vld_q  <= a_vld_q;
            b_last_q <= a_last_q;
            o_valid  <= b_vld_q;
            o_last   <= b_last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!o_hold && a_vld_q) begin
            win_q <= i_window;          // Window formed on the previous accept
        end
        if (!o_hold && b_vld_q) begin
            o_data <= result;
        end
    end

    always_comb begin
        cols[0] = win_q.left;
        cols[1] = win_q.middle;
        cols[2] = win_q.right;
        acc = '0;
        for (int c = 0; c < KERNEL_SIZE; c++) begin
            acc += mul(cols[c].oldest, i_coeff.weight[c]);
            acc += mul(cols[c].middle, i_coeff.weight[KERNEL_SIZE+c]);
            acc += mul(cols[c].newest, i_coeff.weight[2*KERNEL_SIZE+c]);
        end
    end

    assign scaled = acc[FRAC_BITS +: PIXEL_BITS];       // Truncate, wrap on overflow
    assign biased = scaled + i_coeff.bias;
    assign result = (i_relu_en && biased[PIXEL_BITS-1]) ? '0 : biased;

    // Stalled result must not move
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        o_valid && !i_ready |=> o_valid && $stable(o_data) && $stable(o_last));

endmodule

`default_nettype wire

/* verilog/conv_stream.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_stream import conv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    // Pixel input stream
    input  wire pixel_t i_pixel,
    input  wire logic   i_valid,
    input  wire logic   i_last,
    output logic        o_ready_in,
    // Configuration, stable over an image
    input  wire coeff_t i_coeff,
    input  wire logic   i_relu_en,
    // Result stream
    output pixel_t      o_data,
    output logic        o_valid,
    output logic        o_last,
    input  wire logic   i_ready
);

    logic    accept;        // Pixel taken this cycle
    logic    hold;          // Output register stalled
    col_t    wr_col;
    col_t    rd_col;
    logic    row_sel;       // Line RAM holding the oldest row
    logic    win_valid;
    logic    win_last;
    column_t column;
    window_t window;

    window_ctrl i_window_ctrl (
        .clk         (clk),
        .reset       (reset),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .i_hold      (hold),
        .o_ready_in  (o_ready_in),
        .o_accept    (accept),
        .o_wr_col    (wr_col),
        .o_rd_col    (rd_col),
        .o_row_sel   (row_sel),
        .o_win_valid (win_valid),
        .o_win_last  (win_last)
    );

    line_buffer i_line_buffer (
        .clk       (clk),
        .reset     (reset),
        .i_pixel   (i_pixel),
        .i_accept  (accept),
        .i_wr_col  (wr_col),
        .i_rd_col  (rd_col),
        .i_row_sel (row_sel),
        .o_column  (column)
    );

    window_regs i_window_regs (
        .clk      (clk),
        .reset    (reset),
        .i_accept (accept),
        .i_column (column),
        .o_window (window)
    );

    kernel_mac i_kernel_mac (
        .clk         (clk),
        .reset       (reset),
        .i_window    (window),
        .i_coeff     (i_coeff),
        .i_relu_en   (i_relu_en),
        .i_accept    (accept),
        .i_win_valid (win_valid),
        .i_win_last  (win_last),
        .i_ready     (i_ready),
        .o_data      (o_data),
        .o_valid     (o_valid),
        .o_last      (o_last),
        .o_hold      (hold)
    );

endmodule

`default_nettype wire

/* verification/conv_tb_util.svh */
`ifndef CONV_TB_UTIL_SVH
`define CONV_TB_UTIL_SVH

// Random streams: 0 for stimulus, 1 for output ready
logic [31:0] lfsr_q [2] = '{32'ha669, 32'ha669};

pixel_t img[$];                     // Current image, row major
pixel_t exp_data[$];                // Scoreboard, oldest first
logic   exp_last[$];

// Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One step per bit taken, first bit lands in the highest position
function automatic logic [31:0] draw_bits(int src, int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q[src] = lfsr_step(lfsr_q[src]);
        v = {v[30:0], lfsr_q[src][0]};
    end
    return v;
endfunction

// Sign extended value of the given width
function automatic pixel_t signed_value(int bits);
    logic [31:0] raw;
    raw = draw_bits(0, bits);
    return pixel_t'(raw << (32 - bits)) >>> (32 - bits);
endfunction

// Wide mode uses the full 32 bits so sums overflow and wrap
function automatic void make_image(int rows, logic wide);
    img.delete();
    for (int p = 0; p < rows * IMG_WIDTH; p++) begin
        img.push_back(wide ? pixel_t'(draw_bits(0, 32)) : signed_value(20));   // +-8.0
    end
endfunction

function automatic coeff_t make_coeff(logic wide);
    coeff_t cf;
    for (int i = 0; i < KERNEL_SIZE * KERNEL_SIZE; i++) begin
        cf.weight[i] = wide ? pixel_t'(draw_bits(0, 32)) : signed_value(18);  // +-2.0
    end
    cf.bias = wide ? pixel_t'(draw_bits(0, 32)) : signed_value(19);
    return cf;
endfunction

// Output whose window has its top left pixel at row r, column c
function automatic pixel_t ref_pixel(int r, int c, coeff_t cf, logic relu);
    longint sum;
    pixel_t w;
    pixel_t val;
    sum = 0;
    for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
        for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
            w = cf.weight[kr*KERNEL_SIZE + kc];
            sum += longint'(img[(r + kr)*IMG_WIDTH + c + kc]) * longint'(w);
        end
    end
    val = pixel_t'(sum >>> FRAC_BITS) + cf.bias;   // Drop fraction, keep low 32 bits
    if (relu && val < 0) begin
        val = '0;
    end
    return val;
endfunction

function automatic void queue_expected(int rows, coeff_t cf, logic relu);
    for (int r = 0; r <= rows - KERNEL_SIZE; r++) begin
        for (int c = 0; c <= IMG_WIDTH - KERNEL_SIZE; c++) begin
            exp_data.push_back(ref_pixel(r, c, cf, relu));
            exp_last.push_back(r == rows - KERNEL_SIZE && c == IMG_WIDTH - KERNEL_SIZE);
        end
    end
endfunction

`endif

/* verification/conv_stream_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_stream_tb import conv_pkg::*; ();

    logic   clk;
    logic   reset;
    pixel_t i_pixel;
    logic   i_valid;
    logic   i_last;
    logic   o_ready_in;
    coeff_t i_coeff;
    logic   i_relu_en;
    pixel_t o_data;
    logic   o_valid;
    logic   o_last;
    logic   i_ready;
    logic   bp_en = 1'b0;           // Random ready withholding
    int     heights [8];            // Rows per image with the first fixed at 3
    int     watchdog_cycles = 0;
    int     images_done = 0;        // o_last transfers seen
    int     out_count = 0;
    int     checks = 0;
    int     errors = 0;
    int     err_mark = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    `include "conv_tb_util.svh"

    conv_stream i_conv_stream (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // One cycle in four withheld while enabled
    initial begin
        forever begin
            @(posedge clk);
            #1;
            i_ready = !bp_en || (draw_bits(1, 2) != 0);
        end
    end

    // Scoreboard compare on every output transfer
    always @(posedge clk) begin : compare
        pixel_t exp_d;
        logic   exp_l;
        if (reset === 1'b0 && o_valid === 1'b1 && i_ready === 1'b1) begin
            assert (exp_data.size() > 0) else begin
                $display("Unexpected output %h at %0t, none was queued", o_data, $time);
                errors++;
            end
            if (exp_data.size() > 0) begin
                exp_d = exp_data.pop_front();
                exp_l = exp_last.pop_front();
                checks++;
                assert (o_data === exp_d) else begin
                    $display("CHECK FAILED at %0t: o_data %h, expected %h", $time, o_data, exp_d);
                    errors++;
                end
                assert (o_last === exp_l) else begin
                    $display("CHECK FAILED at %0t: o_last %b, expected %b", $time, o_last, exp_l);
                    errors++;
                end
            end
            out_count++;
            if (o_last === 1'b1) begin
                images_done++;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped making progress", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Starts and ends 1 ns after a rising edge
    task automatic send_image(input int rows, input logic gaps);
        int n;
        n = rows * IMG_WIDTH;
        for (int p = 0; p < n; p++) begin
            if (gaps && draw_bits(0, 2) == 0) begin
                i_valid = 1'b0;
                repeat (1 + draw_bits(0, 2)) @(posedge clk);
                #1;
            end
            i_pixel = img[p];
            i_valid = 1'b1;
            i_last  = (p == n - 1);
            do @(posedge clk); while (o_ready_in !== 1'b1);
            #1;
        end
        i_valid = 1'b0;
        i_last  = 1'b0;
    endtask

    task automatic run_image(input int rows, input logic relu, input logic wide,
                             input logic stalls);
        int target;
        int first;
        make_image(rows, wide);
        i_coeff   = make_coeff(wide);
        i_relu_en = relu;
        bp_en     <= stalls;
        queue_expected(rows, i_coeff, relu);
        target = images_done + 1;
        first  = out_count;
        send_image(rows, stalls);
        wait (images_done == target);       // Config held until o_last has left
        #1;
        assert (out_count - first == (rows - 2) * (IMG_WIDTH - 2)) else begin
            $display("CHECK FAILED at %0t: %0d outputs for %0d rows", $time,
                     out_count - first, rows);
            errors++;
        end
        assert (exp_data.size() == 0) else begin
            $display("Image of %0d rows ended with %0d results missing", rows, exp_data.size());
            errors++;
            exp_data.delete();
            exp_last.delete();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("Test %0d %-30s %s", tests_run, name, (errors == err_mark) ? "pass" : "fail");
        err_mark = errors;
    endtask

    initial begin : main
        int total;
        int waited;
        reset     = 1'b1;
        i_pixel   = '0;
        i_valid   = 1'b0;
        i_last    = 1'b0;
        i_coeff   = '0;
        i_relu_en = 1'b0;
        i_ready   = 1'b1;
        total     = 0;
        heights[0] = 3;
        for (int i = 1; i < 8; i++) begin
            heights[i] = 3 + int'(draw_bits(0, 2));     // 3 to 6 rows
        end
        foreach (heights[i]) begin
            total += heights[i] * IMG_WIDTH;
        end
        watchdog_cycles = 4 * total + 200;

        // Idle outputs expected once the first edge has cleared the flops
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            if (k > 0) begin
                assert (o_valid === 1'b0 && o_last === 1'b0 && o_ready_in === 1'b0) else begin
                    $display("CHECK FAILED at %0t: outputs not idle in reset", $time);
                    errors++;
                end
            end
        end
        #1;
        reset  = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (o_ready_in !== 1'b1 && waited < 4);
        assert (o_ready_in === 1'b1) else begin
            $display("Input ready did not rise within 4 cycles of reset release");
            errors++;
        end
        assert (o_valid === 1'b0 && o_last === 1'b0) else begin
            $display("CHECK FAILED at %0t: output valid after reset", $time);
            errors++;
        end
        #1;
        finish_test("reset state");

        run_image(heights[0], 1'b0, 1'b0, 1'b0);
        finish_test("3 rows, free flowing");
        run_image(heights[1], 1'b1, 1'b0, 1'b1);
        finish_test("ReLU on, gaps and stalls");
        run_image(heights[2], 1'b0, 1'b0, 1'b1);
        finish_test("ReLU off, gaps and stalls");
        run_image(heights[3], 1'b0, 1'b1, 1'b1);
        finish_test("full range values, wrap");
        for (int i = 4; i < 8; i++) begin
            run_image(heights[i], draw_bits(0, 1) != 0, 1'b0, 1'b1);
        end
        finish_test("back to back images");

        $display("%0d tests, %0d failed, %0d outputs checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verification
verilog/conv_pkg.sv
verilog/window_ctrl.sv
verilog/line_buffer.sv
verilog/window_regs.sv
verilog/kernel_mac.sv
verilog/conv_stream.sv
verification/conv_stream_tb.sv

/* Bender.yml */
package:
  name: conv_stream

sources:
  # Synthesizable design, package first
  - files:
      - verilog/conv_pkg.sv
      - verilog/window_ctrl.sv
      - verilog/line_buffer.sv
      - verilog/window_regs.sv
      - verilog/kernel_mac.sv
      - verilog/conv_stream.sv

  # Testbench, only for simulation
  - target: test
    include_dirs:
      - verification
    files:
      - verification/conv_stream_tb.sv
